// ==== source/fetch_pkg.sv ====
package fetch_pkg;

  // core widths
  localparam int num_super  = 2;
  localparam int num_fb     = 8;  // power of two, pointers wrap
  localparam int fb_aw      = $clog2(num_fb);
  localparam int pc_w       = 64;
  localparam int inst_w     = 32;
  localparam int imem_depth = 256;
  localparam int imem_aw    = 8;
  localparam int axil_aw    = 12;
  localparam int axil_dw    = 32;
  localparam int disp_w     = 21; // branch displacement field

  localparam logic [pc_w-1:0] inst_bytes = 4;

  // unconditional branch opcodes
  localparam logic [5:0] op_br  = 6'h30;
  localparam logic [5:0] op_bsr = 6'h34;

  // register map, byte addresses
  localparam logic [axil_aw-1:0] reg_ctrl     = 12'h000;
  localparam logic [axil_aw-1:0] reg_redir_lo = 12'h008;
  localparam logic [axil_aw-1:0] reg_redir_hi = 12'h00C;
  localparam logic [axil_aw-1:0] imem_base    = 12'h400;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic [pc_w-1:0]   npc;
    logic [inst_w-1:0] inst;
    logic [pc_w-1:0]   target;
    logic              valid;
  } inst_entry_t;

  typedef struct packed {
    logic [num_super-1:0][pc_w-1:0]   npc;
    logic [num_super-1:0][inst_w-1:0] inst;
    logic [num_super-1:0][pc_w-1:0]   target;
    logic [num_super-1:0]             valid;
  } fetch_pair_t;

  typedef struct packed {
    logic [num_super-1:0][pc_w-1:0]   npc;
    logic [num_super-1:0][inst_w-1:0] inst;
    logic [num_super-1:0][pc_w-1:0]   target;
    logic                             valid;
  } fb_out_t;

  typedef struct packed {
    logic            run;
    logic            redirect;   // single cycle
    logic [pc_w-1:0] redirect_pc;
  } fetch_cfg_t;

  typedef struct packed {
    logic               en;
    logic [imem_aw-1:0] addr;
    logic [inst_w-1:0]  data;
  } imem_wr_t;

  typedef struct packed {
    logic               awvalid;
    logic [axil_aw-1:0] awaddr;
    logic               wvalid;
    logic [axil_dw-1:0] wdata;
    logic [3:0]         wstrb;
    logic               bready;
    logic               arvalid;
    logic [axil_aw-1:0] araddr;
    logic               rready;
  } axil_req_t;

  typedef struct packed {
    logic               awready;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               arready;
    logic               rvalid;
    logic [axil_dw-1:0] rdata;
    logic [1:0]         rresp;
  } axil_rsp_t;

endpackage

// ==== source/fetch_ctrl_regs.sv ====
module fetch_ctrl_regs (
  input  logic                   clock,
  input  logic                   arst_n,
  input  fetch_pkg::axil_req_t   axil_req,
  output fetch_pkg::axil_rsp_t   axil_rsp,
  output fetch_pkg::fetch_cfg_t  cfg,
  output fetch_pkg::imem_wr_t    imem_wr
);

  logic                          run;
  logic [fetch_pkg::axil_dw-1:0] redir_lo;
  logic [fetch_pkg::axil_dw-1:0] redir_hi;
  logic [fetch_pkg::axil_dw-1:0] hi_merged; // high word with strobes applied
  logic [fetch_pkg::axil_dw-1:0] lo_merged;
  logic [fetch_pkg::axil_aw-1:0] mem_off;
  logic                          wr_accept;
  logic                          rd_accept;
  logic                          wr_ctrl;
  logic                          wr_lo;
  logic                          wr_hi;
  logic                          wr_mem;
  logic                          bvalid;
  logic [1:0]                    bresp;
  logic                          rvalid;
  logic [1:0]                    rresp;
  logic [fetch_pkg::axil_dw-1:0] rdata;
  logic [fetch_pkg::axil_dw-1:0] rd_word;
  logic                          rd_hit;

  function automatic logic [fetch_pkg::axil_dw-1:0] merge_strb(
    input logic [fetch_pkg::axil_dw-1:0] old_word,
    input logic [fetch_pkg::axil_dw-1:0] new_word,
    input logic [3:0]                    strb
  );
    logic [fetch_pkg::axil_dw-1:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // one write and one read in flight at most
  assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_accept = axil_req.arvalid & ~rvalid;

  assign wr_ctrl = wr_accept & (axil_req.awaddr == fetch_pkg::reg_ctrl);
  assign wr_lo   = wr_accept & (axil_req.awaddr == fetch_pkg::reg_redir_lo);
  assign wr_hi   = wr_accept & (axil_req.awaddr == fetch_pkg::reg_redir_hi);
  assign wr_mem  = wr_accept & (axil_req.awaddr[11:10] == 2'b01); // 0x400..0x7fc

  assign lo_merged = merge_strb(redir_lo, axil_req.wdata, axil_req.wstrb);
  assign hi_merged = merge_strb(redir_hi, axil_req.wdata, axil_req.wstrb);

  // memory writes are whole words
  assign mem_off      = axil_req.awaddr - fetch_pkg::imem_base;
  assign imem_wr.en   = wr_mem;
  assign imem_wr.addr = mem_off[fetch_pkg::imem_aw+1:2];
  assign imem_wr.data = axil_req.wdata;

  // new pc is visible in the same cycle as the pulse
  assign cfg.run         = run;
  assign cfg.redirect    = wr_hi;
  assign cfg.redirect_pc = {(wr_hi ? hi_merged : redir_hi), redir_lo};

  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (axil_req.araddr)
      fetch_pkg::reg_ctrl:     rd_word[0] = run;
      fetch_pkg::reg_redir_lo: rd_word = redir_lo;
      fetch_pkg::reg_redir_hi: rd_word = redir_hi;
      default:                 rd_hit = 1'b0; // includes the memory window
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      run      <= 1'b0;
      redir_lo <= '0;
      redir_hi <= '0;
      bvalid   <= 1'b0;
      bresp    <= fetch_pkg::resp_okay;
      rvalid   <= 1'b0;
      rresp    <= fetch_pkg::resp_okay;
    end else begin
      if (wr_ctrl && axil_req.wstrb[0]) run <= axil_req.wdata[0];
      if (wr_lo) redir_lo <= lo_merged;
      if (wr_hi) redir_hi <= hi_merged;

      if (wr_accept) begin
        bvalid <= 1'b1;
        bresp  <= (wr_ctrl | wr_lo | wr_hi | wr_mem) ? fetch_pkg::resp_okay
                                                      : fetch_pkg::resp_slverr;
      end else if (axil_req.bready) begin
        bvalid <= 1'b0;
      end

      if (rd_accept) begin
        rvalid <= 1'b1;
        rresp  <= rd_hit ? fetch_pkg::resp_okay : fetch_pkg::resp_slverr;
      end else if (axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_accept) rdata <= rd_word;
  end

  assign axil_rsp.awready = wr_accept;
  assign axil_rsp.wready  = wr_accept;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.arready = rd_accept;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;

  a_bvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
    bvalid && !axil_req.bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clock) disable iff (!arst_n)
    rvalid && !axil_req.rready |=> rvalid && $stable(rdata))
    else $error("read response changed before rready");

  a_redirect_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    cfg.redirect |=> !cfg.redirect)
    else $error("redirect held for two cycles");

endmodule

// ==== source/inst_mem.sv ====
module inst_mem (
  input  logic                                                  clock,
  input  fetch_pkg::imem_wr_t                                   imem_wr,
  input  logic [fetch_pkg::num_super-1:0][fetch_pkg::imem_aw-1:0] rd_addr,
  output logic [fetch_pkg::num_super-1:0][fetch_pkg::inst_w-1:0]  rd_data
);

  // plain word array, loaded over axi before fetch runs
  logic [fetch_pkg::inst_w-1:0] mem [fetch_pkg::imem_depth];

  always_ff @(posedge clock) begin
    if (imem_wr.en) begin
      mem[imem_wr.addr] <= imem_wr.data;
    end
  end

  // async read, one port per fetch slot
  always_comb begin
    for (int k = 0; k < fetch_pkg::num_super; k++) begin
      rd_data[k] = mem[rd_addr[k]];
    end
  end

endmodule

// ==== source/fetch_stage.sv ====
module fetch_stage (
  input  logic                                                  clock,
  input  logic                                                  arst_n,
  input  fetch_pkg::fetch_cfg_t                                 cfg,
  input  logic                                                  fetch_en,
  output logic [fetch_pkg::num_super-1:0][fetch_pkg::imem_aw-1:0] rd_addr,
  input  logic [fetch_pkg::num_super-1:0][fetch_pkg::inst_w-1:0]  rd_data,
  output fetch_pkg::fetch_pair_t                                pair
);

  logic [fetch_pkg::pc_w-1:0]                          pc;
  logic [fetch_pkg::pc_w-1:0]                          next_pc;
  logic [fetch_pkg::num_super-1:0][fetch_pkg::pc_w-1:0] slot_pc;
  logic [fetch_pkg::num_super-1:0]                     is_br;

  function automatic logic is_ubranch(input logic [fetch_pkg::inst_w-1:0] inst);
    logic [5:0] opc;
    opc = inst[31:26];
    return (opc == fetch_pkg::op_br) || (opc == fetch_pkg::op_bsr);
  endfunction

  // sign extended displacement, in bytes
  function automatic logic [fetch_pkg::pc_w-1:0] br_offset(
    input logic [fetch_pkg::inst_w-1:0] inst
  );
    logic [fetch_pkg::disp_w-1:0] disp;
    disp = inst[fetch_pkg::disp_w-1:0];
    return {{(fetch_pkg::pc_w-fetch_pkg::disp_w-2){disp[fetch_pkg::disp_w-1]}}, disp, 2'b00};
  endfunction

  always_comb begin
    slot_pc[0] = pc;
    for (int k = 1; k < fetch_pkg::num_super; k++) begin
      slot_pc[k] = slot_pc[k-1] + fetch_pkg::inst_bytes;
    end

    for (int k = 0; k < fetch_pkg::num_super; k++) begin
      rd_addr[k]     = slot_pc[k][fetch_pkg::imem_aw+1:2]; // wraps at end of memory
      is_br[k]       = is_ubranch(rd_data[k]);
      pair.inst[k]   = rd_data[k];
      pair.npc[k]    = slot_pc[k] + fetch_pkg::inst_bytes;
      pair.target[k] = is_br[k] ? pair.npc[k] + br_offset(rd_data[k]) : pair.npc[k];
    end

    // anything after a taken branch is dropped
    pair.valid[0] = 1'b1;
    for (int k = 1; k < fetch_pkg::num_super; k++) begin
      pair.valid[k] = pair.valid[k-1] & ~is_br[k-1];
    end

    // follow the last live slot
    next_pc = pair.target[0];
    for (int k = 1; k < fetch_pkg::num_super; k++) begin
      if (pair.valid[k]) next_pc = pair.target[k];
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (cfg.redirect) begin
      pc <= cfg.redirect_pc;
    end else if (fetch_en) begin
      pc <= next_pc;
    end
  end

endmodule

// ==== source/fetch_buffer.sv ====
module fetch_buffer (
  input  logic                   clock,
  input  logic                   arst_n,
  input  fetch_pkg::fetch_cfg_t  cfg,
  input  fetch_pkg::fetch_pair_t pair,
  input  logic                   decode_ready,
  output fetch_pkg::fb_out_t     dec_out,
  output logic                   fetch_en
);

  fetch_pkg::inst_entry_t [fetch_pkg::num_fb-1:0] fb;
  fetch_pkg::inst_entry_t [fetch_pkg::num_fb-1:0] fb_next;

  logic [fetch_pkg::fb_aw-1:0] head;
  logic [fetch_pkg::fb_aw-1:0] tail;
  logic [fetch_pkg::fb_aw-1:0] head_p1;
  logic [fetch_pkg::fb_aw-1:0] tail_p1;
  logic [fetch_pkg::fb_aw-1:0] head_next;
  logic [fetch_pkg::fb_aw-1:0] tail_next;
  logic                        take_one;
  logic                        take_two;
  logic                        pair_ready;
  logic                        pop;

  function automatic fetch_pkg::inst_entry_t slot_entry(
    input fetch_pkg::fetch_pair_t p,
    input int                     k
  );
    fetch_pkg::inst_entry_t e;
    e.npc    = p.npc[k];
    e.inst   = p.inst[k];
    e.target = p.target[k];
    e.valid  = 1'b1;
    return e;
  endfunction

  assign head_p1 = head + 1'b1;
  assign tail_p1 = tail + 1'b1;

  always_comb begin
    take_one = 1'b0;
    take_two = 1'b0;
    case (pair.valid)
      2'b01, 2'b10: take_one = 1'b1;
      2'b11:        take_two = 1'b1;
      default: ;
    endcase
  end

  // need a free slot at head for each live instruction
  assign fetch_en = cfg.run & ~cfg.redirect &
                    ((take_one & ~fb[head].valid) |
                     (take_two & ~fb[head].valid & ~fb[head_p1].valid));

  assign pair_ready = fb[tail].valid & fb[tail_p1].valid;
  assign pop        = dec_out.valid & decode_ready;

  always_comb begin
    dec_out.npc    = {fb[tail_p1].npc,    fb[tail].npc};
    dec_out.inst   = {fb[tail_p1].inst,   fb[tail].inst};
    dec_out.target = {fb[tail_p1].target, fb[tail].target};
    dec_out.valid  = pair_ready & cfg.run; // held while frozen
  end

  assign head_next = !fetch_en ? head :
                     take_two  ? head + 2'd2 : head_p1;
  assign tail_next = pop ? tail + 2'd2 : tail;

  always_comb begin
    fb_next = fb;
    if (fetch_en) begin
      if (take_two) begin
        fb_next[head]    = slot_entry(pair, 0);
        fb_next[head_p1] = slot_entry(pair, 1);
      end else begin
        fb_next[head] = slot_entry(pair, pair.valid[0] ? 0 : 1); // lone live slot
      end
    end
    if (pop) begin
      fb_next[tail].valid    = 1'b0;
      fb_next[tail_p1].valid = 1'b0;
    end
  end

  // payload fields keep their value through reset
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < fetch_pkg::num_fb; i++) begin
        fb[i].valid <= 1'b0;
      end
    end else if (cfg.redirect) begin
      head <= '0; // flush
      tail <= '0;
      for (int i = 0; i < fetch_pkg::num_fb; i++) begin
        fb[i].valid <= 1'b0;
      end
    end else if (cfg.run) begin
      fb   <= fb_next;
      head <= head_next;
      tail <= tail_next;
    end
  end

  a_no_fetch_on_redirect: assert property (@(posedge clock) disable iff (!arst_n)
    cfg.redirect |-> !fetch_en)
    else $error("fetch enabled during redirect");

  // tail only moves on a handed-over pair
  a_no_pop_when_invalid: assert property (@(posedge clock) disable iff (!arst_n)
    !dec_out.valid && !cfg.redirect |=> tail == $past(tail))
    else $error("pop without a valid pair");

endmodule

// ==== source/fetch_top.sv ====
module fetch_top (
  input  logic                 clock,
  input  logic                 arst_n,
  input  fetch_pkg::axil_req_t axil_req,
  output fetch_pkg::axil_rsp_t axil_rsp,
  input  logic                 decode_ready,
  output fetch_pkg::fb_out_t   dec_out
);

  fetch_pkg::fetch_cfg_t                                  cfg;
  fetch_pkg::imem_wr_t                                    imem_wr;
  fetch_pkg::fetch_pair_t                                 pair;
  logic [fetch_pkg::num_super-1:0][fetch_pkg::imem_aw-1:0] rd_addr;
  logic [fetch_pkg::num_super-1:0][fetch_pkg::inst_w-1:0]  rd_data;
  logic                                                   fetch_en;

  fetch_ctrl_regs regs0 (
    .clock    (clock),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg),
    .imem_wr  (imem_wr)
  );

  inst_mem imem0 (
    .clock   (clock),
    .imem_wr (imem_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  fetch_stage if0 (
    .clock    (clock),
    .arst_n   (arst_n),
    .cfg      (cfg),
    .fetch_en (fetch_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .pair     (pair)
  );

  // throttles fetch through fetch_en
  fetch_buffer fb0 (
    .clock        (clock),
    .arst_n       (arst_n),
    .cfg          (cfg),
    .pair         (pair),
    .decode_ready (decode_ready),
    .dec_out      (dec_out),
    .fetch_en     (fetch_en)
  );

endmodule

// ==== testbench/fetch_tb.sv ====
module fetch_tb;

  localparam int pairs_per_run  = 120;
  localparam int stream_runs    = 4;
  localparam int worst_pair_cyc = 8;  // decode_ready can sit near 40 percent
  localparam int axi_ops        = 2 * fetch_pkg::imem_depth + 80;
  localparam int axi_op_cyc     = 6;
  localparam int cycle_limit    = 2 * pairs_per_run * stream_runs * worst_pair_cyc
                                  + axi_ops * axi_op_cyc;

  logic                 clock;
  logic                 arst_n;
  logic                 decode_ready;
  fetch_pkg::axil_req_t axil_req;
  fetch_pkg::axil_rsp_t axil_rsp;
  fetch_pkg::fb_out_t   dec_out;

  int seed       = 85231;
  int ready_seed = 85231;
  int ready_pct  = 0;
  int errors     = 0;
  int test_err0  = 0;
  int tests_run  = 0;
  int pairs_seen = 0;
  int cycles     = 0;

  // reference copy of the program and the expected entry stream
  logic [31:0]            mem_model [fetch_pkg::imem_depth];
  fetch_pkg::inst_entry_t exp_q [$];
  fetch_pkg::inst_entry_t exp_e;
  logic [63:0]            model_pc;
  logic [31:0]            lo_seen = '0;
  logic                   armed   = 1'b0;
  logic [31:0]            ctrl_sh = '0;
  logic [31:0]            lo_sh   = '0;
  logic [31:0]            hi_sh   = '0;

  fetch_top dut0 (
    .clock        (clock),
    .arst_n       (arst_n),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .decode_ready (decode_ready),
    .dec_out      (dec_out)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(negedge clock) begin
    decode_ready = ((($random(ready_seed) & 32'h7fffffff) % 100) < ready_pct);
  end

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
    errors++;
  endtask

  // walk the stream one word at a time following branch targets
  task automatic extend_model();
    logic [31:0]            w;
    logic [63:0]            npc;
    logic [63:0]            tgt;
    logic signed [63:0]     disp;
    fetch_pkg::inst_entry_t e;
    while (exp_q.size() < fetch_pkg::num_super) begin
      w   = mem_model[model_pc[9:2]];
      npc = model_pc + 64'd4;
      tgt = npc;
      if (w[31:26] == fetch_pkg::op_br || w[31:26] == fetch_pkg::op_bsr) begin
        disp = $signed(w[20:0]); // signed word count
        tgt  = npc + disp * 4;
      end
      e.npc    = npc;
      e.inst   = w;
      e.target = tgt;
      e.valid  = 1'b1;
      exp_q.push_back(e);
      model_pc = tgt; // word after a taken branch never shows up
    end
  endtask

  // bus-side view of redirects and the pair checker
  always @(posedge clock) begin
    if (axil_rsp.awready && axil_req.awaddr == fetch_pkg::reg_redir_lo) begin
      lo_seen = axil_req.wdata;
    end
    if (axil_rsp.awready && axil_req.awaddr == fetch_pkg::reg_redir_hi) begin
      model_pc = {axil_req.wdata, lo_seen};
      exp_q.delete();
      armed = 1'b1;
    end else if (armed && dec_out.valid && decode_ready) begin
      extend_model();
      for (int k = 0; k < fetch_pkg::num_super; k++) begin
        exp_e = exp_q.pop_front();
        if (dec_out.inst[k] !== exp_e.inst)
          report_mismatch($sformatf("dec_out.inst[%0d]", k), dec_out.inst[k], exp_e.inst);
        if (dec_out.npc[k] !== exp_e.npc)
          report_mismatch($sformatf("dec_out.npc[%0d]", k), dec_out.npc[k], exp_e.npc);
        if (dec_out.target[k] !== exp_e.target)
          report_mismatch($sformatf("dec_out.target[%0d]", k), dec_out.target[k],
                          exp_e.target);
      end
      pairs_seen++;
    end
  end

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge clock);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.bready  = 1'b1;
    @(posedge clock);
    while (!axil_rsp.awready) @(posedge clock);
    if (axil_rsp.wready !== 1'b1)
      report_mismatch("axil_rsp.wready", axil_rsp.wready, 1);
    @(negedge clock);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) @(negedge clock);
    resp = axil_rsp.bresp;
    @(negedge clock); // response taken at the edge in between
    axil_req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clock);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    @(posedge clock);
    while (!axil_rsp.arready) @(posedge clock);
    @(negedge clock);
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) @(negedge clock);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clock);
    axil_req.rready = 1'b0;
  endtask

  task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    if (resp !== fetch_pkg::resp_okay)
      report_mismatch("axil_rsp.bresp", resp, fetch_pkg::resp_okay);
    if (addr == fetch_pkg::reg_ctrl) ctrl_sh = {31'd0, data[0]};
    if (addr == fetch_pkg::reg_redir_lo) lo_sh = data;
    if (addr == fetch_pkg::reg_redir_hi) hi_sh = data;
  endtask

  task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(addr, data, resp);
    if (resp !== fetch_pkg::resp_okay)
      report_mismatch("axil_rsp.rresp", resp, fetch_pkg::resp_okay);
    if (data !== exp) report_mismatch(name, data, exp);
  endtask

  // random words with about one in eight optionally made into br or bsr
  task automatic load_program(input bit with_branches);
    logic [31:0] w;
    int          d;
    for (int i = 0; i < fetch_pkg::imem_depth; i++) begin
      w = $random(seed);
      if (w[31:26] == fetch_pkg::op_br || w[31:26] == fetch_pkg::op_bsr) w[26] = ~w[26];
      if (with_branches && ($random(seed) & 7) == 0) begin
        d        = $random(seed) % 7; // small displacement in either direction
        w[31:26] = ($random(seed) & 1) ? fetch_pkg::op_bsr : fetch_pkg::op_br;
        w[20:0]  = d[20:0];
      end
      mem_model[i] = w;
      write_ok(fetch_pkg::imem_base + 12'(4 * i), w);
    end
  endtask

  function automatic logic [63:0] random_pc();
    logic [63:0] pc;
    pc[63:32] = $random(seed);
    pc[31:0]  = $random(seed);
    pc[1:0]   = 2'b00;
    return pc;
  endfunction

  // the high word write fires the redirect
  task automatic redirect_to(input logic [63:0] pc);
    write_ok(fetch_pkg::reg_redir_lo, pc[31:0]);
    write_ok(fetch_pkg::reg_redir_hi, pc[63:32]);
  endtask

  task automatic wait_pairs(input int n);
    int target;
    target = pairs_seen + n;
    while (pairs_seen < target) @(negedge clock);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin
    logic [63:0] pc;
    logic [31:0] v;
    logic [31:0] data;
    logic [1:0]  resp;
    clock        = 1'b0;
    arst_n       = 1'b0;
    decode_ready = 1'b0;
    axil_req     = '0;
    repeat (4) @(negedge clock);
    arst_n = 1'b1;

    if (dec_out.valid !== 1'b0) report_mismatch("dec_out.valid", dec_out.valid, 0);
    if (axil_rsp.bvalid !== 1'b0) report_mismatch("axil_rsp.bvalid", axil_rsp.bvalid, 0);
    if (axil_rsp.rvalid !== 1'b0) report_mismatch("axil_rsp.rvalid", axil_rsp.rvalid, 0);
    read_check(fetch_pkg::reg_ctrl, 32'd0, "reg_ctrl");
    end_test("reset state");

    load_program(1'b0); // straight-line code also backs the readback test
    ready_pct = 70;
    repeat (3) begin
      v = $random(seed);
      write_ok(fetch_pkg::reg_ctrl, v);
      read_check(fetch_pkg::reg_ctrl, {31'd0, v[0]}, "reg_ctrl");
      pc = random_pc();
      redirect_to(pc);
      read_check(fetch_pkg::reg_redir_lo, pc[31:0], "reg_redir_lo");
      read_check(fetch_pkg::reg_redir_hi, pc[63:32], "reg_redir_hi");
    end
    write_ok(fetch_pkg::reg_ctrl, 32'd0);
    end_test("register readback");

    redirect_to(random_pc());
    write_ok(fetch_pkg::reg_ctrl, 32'd1);
    wait_pairs(pairs_per_run);
    write_ok(fetch_pkg::reg_ctrl, 32'd0);
    end_test("straight-line stream");

    load_program(1'b1);
    redirect_to(random_pc());
    write_ok(fetch_pkg::reg_ctrl, 32'd1);
    wait_pairs(pairs_per_run);
    end_test("branch following");

    ready_pct = 40; // heavier back-pressure
    repeat (4) begin
      wait_pairs(1 + (($random(seed) & 32'h7fffffff) % 20));
      redirect_to(random_pc());
    end
    wait_pairs(pairs_per_run);
    write_ok(fetch_pkg::reg_ctrl, 32'd0);
    end_test("redirect flush");

    v = $random(seed);
    axi_write(12'h100 | (v[11:0] & 12'h0fc), ~v, resp);
    if (resp !== fetch_pkg::resp_slverr)
      report_mismatch("axil_rsp.bresp", resp, fetch_pkg::resp_slverr);
    axi_read(12'h100 | (v[11:0] & 12'h0fc), data, resp);
    if (resp !== fetch_pkg::resp_slverr)
      report_mismatch("axil_rsp.rresp", resp, fetch_pkg::resp_slverr);
    axi_read(fetch_pkg::imem_base | (v[11:0] & 12'h3fc), data, resp);
    if (resp !== fetch_pkg::resp_slverr)
      report_mismatch("axil_rsp.rresp", resp, fetch_pkg::resp_slverr);
    read_check(fetch_pkg::reg_ctrl, ctrl_sh, "reg_ctrl");
    read_check(fetch_pkg::reg_redir_lo, lo_sh, "reg_redir_lo");
    read_check(fetch_pkg::reg_redir_hi, hi_sh, "reg_redir_hi");
    end_test("error response");

    $display("tests %0d, pairs checked %0d, errors %0d", tests_run, pairs_seen, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/fetch_pkg.sv
source/fetch_ctrl_regs.sv
source/inst_mem.sv
source/fetch_stage.sv
source/fetch_buffer.sv
source/fetch_top.sv
testbench/fetch_tb.sv
